// File: lbp_core.f
+incdir+logic
logic/lbp_pkg.sv
logic/sync_fifo.sv
logic/diag_interp.sv
logic/lbp_encoder.sv
logic/wb_sample_loader.sv
logic/lbp_core.sv
verif/tb_lbp_core.sv

// File: Makefile
# Verilator build and run for the LBP core testbench

VERILATOR ?= verilator
TOP       ?= tb_lbp_core
FILELIST  ?= lbp_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test passed
FAIL_MSG  ?= Test failed
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?=

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-$(BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "Simulation clean"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/tb_lbp_core.sv
`timescale 1ns/1ps
`include "lbp_defs.svh"

module tb_lbp_core;

    localparam int CLK_PERIOD    = 40;
    localparam int DRIVE_DELAY   = 2;
    localparam int ACK_TIMEOUT   = 200;
    localparam int STALL_CYCLES  = 10;
    localparam int DRAIN_TIMEOUT = 4000;
    localparam int NUM_RANDOM    = 40;
    localparam int NUM_PRESSURE  = `LBP_SET_DEPTH + `LBP_RES_DEPTH + 4;

    logic       clk;
    logic       rst;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    logic [4:0] wb_adr;
    logic [7:0] wb_dat_w;
    logic [7:0] wb_dat_r;
    logic       wb_ack;
    logic       code_valid;
    logic [7:0] code;
    logic [7:0] center;
    logic       code_ready;

    lbp_pkg::lbp_result_t exp_q [$];

    logic        head_valid;
    logic [7:0]  head_code;
    logic [7:0]  head_center;
    logic        take_pending;
    logic        bus_started;
    logic        stall_seen;
    logic        release_on_stall;
    logic [15:0] lfsr;

    lbp_core u_lbp_core (
        .clk          (clk),
        .rst          (rst),
        .wb_cyc_i     (wb_cyc),
        .wb_stb_i     (wb_stb),
        .wb_we_i      (wb_we),
        .wb_adr_i     (wb_adr),
        .wb_dat_i     (wb_dat_w),
        .wb_dat_o     (wb_dat_r),
        .wb_ack_o     (wb_ack),
        .code_valid_o (code_valid),
        .code_o       (code),
        .center_o     (center),
        .code_ready_i (code_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [7:0] got,
                                   input logic [7:0] exp);
        abort_run($sformatf("Fail at %0d ns: %s = 0x%02h, expected 0x%02h",
                            $time, name, got, exp));
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else report_mismatch(name, got, exp);
    endtask

    // Galois LFSR, one step per bit
    function automatic logic [7:0] rand_byte();
        logic [7:0] v;
        for (int i = 0; i < 8; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic lbp_pkg::sample_set_t rand_set();
        lbp_pkg::sample_set_t s;
        s.center = rand_byte();
        for (int k = 0; k < 4; k++) begin
            s.axial[k]  = rand_byte();
            s.diag[k].a = rand_byte();
            s.diag[k].b = rand_byte();
            s.diag[k].c = rand_byte();
            s.diag[k].d = rand_byte();
        end
        return s;
    endfunction

    function automatic lbp_pkg::sample_set_t fill_set(input logic [7:0] ctr,
                                                      input logic [7:0] ring);
        lbp_pkg::sample_set_t s;
        s.center = ctr;
        for (int k = 0; k < 4; k++) begin
            s.axial[k] = ring;
            s.diag[k]  = {4{ring}};
        end
        return s;
    endfunction

    // Ring index is the angle in steps of 45 deg, which is also the code bit
    function automatic logic [7:0] expected_code(input lbp_pkg::sample_set_t s);
        int unsigned f;
        int unsigned acc;
        logic [7:0]  ring [8];
        logic [7:0]  res;
        f = lbp_pkg::diag_frac(`LBP_RADIUS);
        for (int k = 0; k < 4; k++) begin
            acc = (256 - f) * (256 - f) * s.diag[k].a
                + f * (256 - f) * (s.diag[k].b + s.diag[k].c)
                + f * f * s.diag[k].d;
            ring[2 * k]     = s.axial[k];
            ring[2 * k + 1] = 8'(acc >> 16);
        end
        for (int i = 0; i < 8; i++) begin
            res[i] = ring[i] >= s.center;
        end
        return res;
    endfunction

    // Starts and ends 2 ns after a rising edge
    task automatic wb_access(input logic we, input logic [4:0] adr, input logic [7:0] wdat,
                             output logic [7:0] rdat);
        int   waited;
        logic acked;
        waited      = 0;
        acked       = 1'b0;
        bus_started = 1'b1;
        wb_cyc      = 1'b1;
        wb_stb      = 1'b1;
        wb_we       = we;
        wb_adr      = adr;
        wb_dat_w    = wdat;
        while (!acked) begin
            @(negedge clk);
            if (wb_ack) begin
                acked = 1'b1;
                rdat  = wb_dat_r;
            end else if (waited >= ACK_TIMEOUT) begin
                abort_run($sformatf("No Wishbone ack within %0d cycles at address %0d",
                                    ACK_TIMEOUT, adr));
            end else begin
                waited++;
                if (release_on_stall && !code_ready && waited > STALL_CYCLES) begin
                    stall_seen = 1'b1;  // Commit held off, let the results drain
                    @(posedge clk);
                    #DRIVE_DELAY code_ready = 1'b1;
                end
            end
        end
        @(posedge clk);
        #DRIVE_DELAY;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [4:0] adr, input logic [7:0] dat);
        logic [7:0] ignored;
        wb_access(1'b1, adr, dat, ignored);
    endtask

    task automatic wb_read(input logic [4:0] adr, output logic [7:0] dat);
        wb_access(1'b0, adr, 8'h00, dat);
    endtask

    task automatic send_set(input lbp_pkg::sample_set_t s);
        lbp_pkg::lbp_result_t r;
        wb_write(5'(`LBP_ADDR_CENTER), s.center);
        for (int k = 0; k < 4; k++) begin
            wb_write(5'(`LBP_ADDR_AXIAL + k), s.axial[k]);
            wb_write(5'(`LBP_ADDR_DIAG + 4 * k), s.diag[k].a);
            wb_write(5'(`LBP_ADDR_DIAG + 4 * k + 1), s.diag[k].b);
            wb_write(5'(`LBP_ADDR_DIAG + 4 * k + 2), s.diag[k].c);
            wb_write(5'(`LBP_ADDR_DIAG + 4 * k + 3), s.diag[k].d);
        end
        r.code   = expected_code(s);
        r.center = s.center;
        exp_q.push_back(r);
        wb_write(5'(`LBP_ADDR_COMMIT), 8'h00);
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            if (waited >= DRAIN_TIMEOUT) begin
                abort_run($sformatf("%0d results missing after drain timeout", exp_q.size()));
            end else begin
                waited++;
            end
        end
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // Transfer seen mid-cycle lands on the next rising edge
    always @(negedge clk) begin
        take_pending <= !rst && code_valid && code_ready;
    end

    always @(posedge clk) begin
        if (take_pending && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
        end
        if (exp_q.size() != 0) begin
            head_valid  <= 1'b1;
            head_code   <= exp_q[0].code;
            head_center <= exp_q[0].center;
        end else begin
            head_valid <= 1'b0;
        end
    end

    a_idle_after_reset : assert property (
        @(posedge clk) disable iff (rst)
        !bus_started |-> !wb_ack && !code_valid
    ) else abort_run("wb_ack_o or code_valid_o rose before the first bus access");

    a_result_expected : assert property (
        @(posedge clk) disable iff (rst)
        code_valid && code_ready |-> head_valid
    ) else abort_run("A result arrived with no committed set waiting for it");

    a_code_match : assert property (
        @(posedge clk) disable iff (rst)
        code_valid && code_ready && head_valid |-> code == head_code
    ) else report_mismatch("code_o", $sampled(code), $sampled(head_code));

    a_center_match : assert property (
        @(posedge clk) disable iff (rst)
        code_valid && code_ready && head_valid |-> center == head_center
    ) else report_mismatch("center_o", $sampled(center), $sampled(head_center));

    initial begin
        lbp_pkg::sample_set_t s;
        logic [7:0]           rd;
        lfsr             = 16'd96;
        bus_started      = 1'b0;
        stall_seen       = 1'b0;
        release_on_stall = 1'b0;
        rst              = 1'b1;
        wb_cyc           = 1'b0;
        wb_stb           = 1'b0;
        wb_we            = 1'b0;
        wb_adr           = '0;
        wb_dat_w         = '0;
        code_ready       = 1'b1;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY rst = 1'b0;
        repeat (3) @(posedge clk);  // Idle bus, nothing may respond
        #DRIVE_DELAY;

        for (int a = 0; a < `LBP_ADDR_COMMIT; a++) begin
            wb_write(5'(a), 8'(a * 37 + 11));
        end
        for (int a = 0; a < `LBP_ADDR_COMMIT; a++) begin
            wb_read(5'(a), rd);
            check_byte($sformatf("wb_dat_o at address %0d", a), rd, 8'(a * 37 + 11));
        end
        wb_write(5'd25, 8'hA5);
        wb_read(5'd25, rd);
        check_byte("wb_dat_o at address 25", rd, 8'h00);

        send_set(fill_set(8'h5A, 8'h5A));
        send_set(fill_set(8'hFF, 8'h00));
        for (int p = 0; p < 8; p++) begin
            s = fill_set(8'd100, 8'd50);
            if (p % 2 == 0) begin
                s.axial[p / 2] = 8'd200;
            end else begin
                s.diag[p / 2] = {4{8'd200}};  // Weights sum to one, so the point is 200
            end
            send_set(s);
        end
        drain_results();

        for (int n = 0; n < NUM_RANDOM; n++) begin
            send_set(rand_set());
        end
        drain_results();

        code_ready       = 1'b0;
        release_on_stall = 1'b1;
        for (int n = 0; n < NUM_PRESSURE; n++) begin
            send_set(rand_set());
        end
        release_on_stall = 1'b0;
        code_ready       = 1'b1;
        drain_results();

        if (!stall_seen) begin
            abort_run("Commit ack never stalled while code_ready_i was low");
        end else if (code_valid) begin
            abort_run("code_valid_o still high after all results arrived");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// File: logic/lbp_core.sv
`timescale 1ns/1ps
`include "lbp_defs.svh"

module lbp_core (
    input  logic       clk,
    input  logic       rst,
    input  logic       wb_cyc_i,
    input  logic       wb_stb_i,
    input  logic       wb_we_i,
    input  logic [4:0] wb_adr_i,
    input  logic [7:0] wb_dat_i,
    output logic [7:0] wb_dat_o,
    output logic       wb_ack_o,
    output logic       code_valid_o,
    output logic [7:0] code_o,
    output logic [7:0] center_o,
    input  logic       code_ready_i
);

    logic                 set_valid;
    logic                 set_ready;
    lbp_pkg::sample_set_t set_data;

    logic                 enc_valid;
    logic                 enc_ready;
    lbp_pkg::sample_set_t enc_data;

    logic                 res_valid;
    logic                 res_ready;
    lbp_pkg::lbp_result_t res_data;

    lbp_pkg::lbp_result_t code_data;

    wb_sample_loader u_loader (
        .clk         (clk),
        .rst         (rst),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .set_ready_i (set_ready),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .set_valid_o (set_valid),
        .set_data_o  (set_data)
    );

    sync_fifo #(
        .T     (lbp_pkg::sample_set_t),
        .DEPTH (`LBP_SET_DEPTH)
    ) u_set_fifo (
        .clk          (clk),
        .rst          (rst),
        .push_valid_i (set_valid),
        .push_data_i  (set_data),
        .push_ready_o (set_ready),
        .pop_valid_o  (enc_valid),
        .pop_data_o   (enc_data),
        .pop_ready_i  (enc_ready)
    );

    lbp_encoder u_encoder (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (enc_valid),
        .in_data_i   (enc_data),
        .in_ready_o  (enc_ready),
        .out_valid_o (res_valid),
        .out_data_o  (res_data),
        .out_ready_i (res_ready)
    );

    sync_fifo #(
        .T     (lbp_pkg::lbp_result_t),
        .DEPTH (`LBP_RES_DEPTH)
    ) u_res_fifo (
        .clk          (clk),
        .rst          (rst),
        .push_valid_i (res_valid),
        .push_data_i  (res_data),
        .push_ready_o (res_ready),
        .pop_valid_o  (code_valid_o),
        .pop_data_o   (code_data),
        .pop_ready_i  (code_ready_i)
    );

    assign code_o   = code_data.code;
    assign center_o = code_data.center;

endmodule

// File: logic/wb_sample_loader.sv
`timescale 1ns/1ps
`include "lbp_defs.svh"

module wb_sample_loader (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  logic [4:0]           wb_adr_i,
    input  logic [7:0]           wb_dat_i,
    input  logic                 set_ready_i,
    output logic [7:0]           wb_dat_o,
    output logic                 wb_ack_o,
    output logic                 set_valid_o,
    output lbp_pkg::sample_set_t set_data_o
);

    localparam int NUM_PIX = `LBP_ADDR_COMMIT;

    lbp_pkg::pixel_t pix_q [NUM_PIX];

    logic ack_q;
    logic commit_q;
    logic req;
    logic is_pix;
    logic is_commit;

    assign req       = wb_cyc_i && wb_stb_i && !ack_q;  // Strobe not yet answered
    assign is_pix    = wb_adr_i < 5'(NUM_PIX);
    assign is_commit = wb_we_i && (wb_adr_i == 5'(`LBP_ADDR_COMMIT));

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q    <= 1'b0;
            commit_q <= 1'b0;
        end else begin
            ack_q    <= req && (!is_commit || set_ready_i);  // Commit waits for space
            commit_q <= req && is_commit && set_ready_i;
        end
    end

    always_ff @(posedge clk) begin
        if (req && wb_we_i && is_pix) begin
            pix_q[wb_adr_i] <= wb_dat_i;
        end
        if (req) begin
            wb_dat_o <= is_pix ? pix_q[wb_adr_i] : 8'h00;  // Unmapped reads as 0
        end
    end

    assign wb_ack_o    = ack_q;
    assign set_valid_o = commit_q;  // Push lands in the ack cycle

    // Register file to sample set layout
    always_comb begin
        set_data_o.center = pix_q[`LBP_ADDR_CENTER];
        for (int k = 0; k < 4; k++) begin
            set_data_o.axial[k]  = pix_q[`LBP_ADDR_AXIAL + k];
            set_data_o.diag[k].a = pix_q[`LBP_ADDR_DIAG + 4 * k];
            set_data_o.diag[k].b = pix_q[`LBP_ADDR_DIAG + 4 * k + 1];
            set_data_o.diag[k].c = pix_q[`LBP_ADDR_DIAG + 4 * k + 2];
            set_data_o.diag[k].d = pix_q[`LBP_ADDR_DIAG + 4 * k + 3];
        end
    end

    a_ack_pulse : assert property (
        @(posedge clk) disable iff (rst)
        wb_ack_o |=> !wb_ack_o
    );

    a_push_in_commit : assert property (
        @(posedge clk) disable iff (rst)
        set_valid_o |-> wb_cyc_i && wb_stb_i && is_commit
    );

endmodule

// File: logic/lbp_encoder.sv
`timescale 1ns/1ps

module lbp_encoder (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid_i,
    input  lbp_pkg::sample_set_t in_data_i,
    output logic                 in_ready_o,
    output logic                 out_valid_o,
    output lbp_pkg::lbp_result_t out_data_o,
    input  logic                 out_ready_i
);

    logic en;
    logic v1_q;
    logic v2_q;
    logic v3_q;

    lbp_pkg::pixel_t       c1_q;
    lbp_pkg::pixel_t       c2_q;
    lbp_pkg::pixel_t [3:0] ax1_q;
    lbp_pkg::pixel_t [3:0] ax2_q;
    lbp_pkg::pixel_t [3:0] diag_val;
    logic            [7:0] code_d;
    lbp_pkg::lbp_result_t  res_q;

    assign en         = !v3_q || out_ready_i;  // Output stage empty or drained
    assign in_ready_o = en;

    always_ff @(posedge clk) begin
        if (rst) begin
            v1_q <= 1'b0;
            v2_q <= 1'b0;
            v3_q <= 1'b0;
        end else if (en) begin
            v1_q <= in_valid_i;
            v2_q <= v1_q;
            v3_q <= v2_q;
        end
    end

    genvar g;
    generate
        for (g = 0; g < 4; g++) begin : g_diag
            diag_interp u_interp (
                .clk     (clk),
                .rst     (rst),
                .en_i    (en),
                .group_i (in_data_i.diag[g]),
                .value_o (diag_val[g])
            );
        end
    endgenerate

    // Centre and axial pixels wait for the interpolators
    always_ff @(posedge clk) begin
        if (en) begin
            c1_q  <= in_data_i.center;
            ax1_q <= in_data_i.axial;
            c2_q  <= c1_q;
            ax2_q <= ax1_q;
        end
    end

    // Even bits axial, odd bits diagonal
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            code_d[2 * k]     = ax2_q[k] >= c2_q;
            code_d[2 * k + 1] = diag_val[k] >= c2_q;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            res_q.code   <= code_d;
            res_q.center <= c2_q;
        end
    end

    assign out_valid_o = v3_q;
    assign out_data_o  = res_q;

    a_hold_stalled : assert property (
        @(posedge clk) disable iff (rst)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o)
    );

endmodule

// File: logic/diag_interp.sv
`timescale 1ns/1ps
`include "lbp_defs.svh"

module diag_interp (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 en_i,
    input  lbp_pkg::diag_group_t group_i,
    output lbp_pkg::pixel_t      value_o
);

    localparam int unsigned F = lbp_pkg::diag_frac(`LBP_RADIUS);

    // Bilinear weights in Q16, summing to 65536
    localparam logic [16:0] W_NEAR = 17'((256 - F) * (256 - F));
    localparam logic [16:0] W_SIDE = 17'(F * (256 - F));
    localparam logic [16:0] W_FAR  = 17'(F * F);

    logic [24:0] p_near_q;
    logic [25:0] p_side_q;  // Carries the b + c sum
    logic [24:0] p_far_q;
    logic [25:0] sum;

    always_ff @(posedge clk) begin
        if (rst) begin
            p_near_q <= '0;
            p_side_q <= '0;
            p_far_q  <= '0;
        end else if (en_i) begin
            p_near_q <= W_NEAR * group_i.a;
            p_side_q <= W_SIDE * (group_i.b + group_i.c);
            p_far_q  <= W_FAR * group_i.d;
        end
    end

    assign sum = p_near_q + p_side_q + p_far_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            value_o <= '0;
        end else if (en_i) begin
            value_o <= sum[23:16];  // Drop the Q16 fraction
        end
    end

endmodule

// File: logic/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic push_valid_i,
    input  T     push_data_i,
    output logic push_ready_o,
    output logic pop_valid_o,
    output T     pop_data_o,
    input  logic pop_ready_i
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T mem_q [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full         = count_q == CNT_W'(DEPTH);
    assign pop_valid_o  = count_q != '0;
    assign push_ready_o = !full || pop_ready_i;  // Full FIFO takes a push alongside a pop
    assign pop_data_o   = mem_q[rd_ptr_q];

    assign do_push = push_valid_i && push_ready_o;
    assign do_pop  = pop_valid_o && pop_ready_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    a_no_overflow : assert property (
        @(posedge clk) disable iff (rst)
        count_q <= CNT_W'(DEPTH)
    );

endmodule

// File: logic/lbp_pkg.sv
package lbp_pkg;

    typedef logic [7:0] pixel_t;

    // Grid pixels around one diagonal point
    typedef struct packed {
        pixel_t a;  // Near corner
        pixel_t b;
        pixel_t c;
        pixel_t d;  // Far corner
    } diag_group_t;

    typedef struct packed {
        pixel_t            center;
        pixel_t      [3:0] axial;  // Index 0 is 0 deg
        diag_group_t [3:0] diag;   // Index 0 is 45 deg
    } sample_set_t;

    typedef struct packed {
        logic [7:0] code;
        pixel_t     center;
    } lbp_result_t;

    // Q8 fractional offset of the diagonal point from the grid
    function automatic logic [7:0] diag_frac(input int radius);
        logic [7:0] f;
        case (radius)
            1:       f = 8'd181;
            2:       f = 8'd106;
            3:       f = 8'd31;
            4:       f = 8'd212;
            default: f = 8'd0;
        endcase
        return f;
    endfunction

endpackage

// File: logic/lbp_defs.svh
`ifndef LBP_DEFS_SVH
`define LBP_DEFS_SVH

// Ring radius in pixels, 1 to 4
`define LBP_RADIUS 2

// FIFO depths in entries
`define LBP_SET_DEPTH 4
`define LBP_RES_DEPTH 4

// Wishbone word addresses
`define LBP_ADDR_CENTER 0
`define LBP_ADDR_AXIAL  1   // 0, 90, 180, 270 deg
`define LBP_ADDR_DIAG   5   // Groups 45..315 deg, each a, b, c, d
`define LBP_ADDR_COMMIT 21

`endif
